// ==== Bender.yml ====
package:
  name: tcam_subsys

sources:
  - include_dirs:
      - include
    files:
      - verilog/tcam_pkg.sv
      - verilog/tcam_array.sv
      - verilog/tcam_indirect_ctrl.sv
      - verilog/tcam_key_fifo.sv
      - verilog/tcam_lookup_engine.sv
      - verilog/tcam_subsys_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_tcam_subsys.sv

// ==== include/tcam_config.svh ====
`ifndef TCAM_CONFIG_SVH
`define TCAM_CONFIG_SVH

// Array geometry. One entry is a value row and a mask row.
`define TCAM_ENTRIES        16
`define TCAM_IDX_BITS       $clog2(`TCAM_ENTRIES)
`define TCAM_KEY_BITS       14

// Controller wait timer; its MSB requests a yield from the lookup engine.
`define TCAM_TIMER_BITS     6

`define TCAM_FIFO_DEPTH     4

// Register map of the indirect access port.
`define TCAM_REG_ADDR_BITS  8
`define TCAM_CMND_ADDR      8'h00
`define TCAM_DATA_ADDR      8'h04
`define TCAM_STAT_ADDR      8'h08

`endif

// ==== list.f ====
+incdir+include
verilog/tcam_pkg.sv
verilog/tcam_array.sv
verilog/tcam_indirect_ctrl.sv
verilog/tcam_key_fifo.sv
verilog/tcam_lookup_engine.sv
verilog/tcam_subsys_top.sv
sim/tb_tcam_subsys.sv

// ==== sim/tb_tcam_subsys.sv ====
`timescale 1ns/1ps
`include "tcam_config.svh"

module tb_tcam_subsys
  import tcam_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20000; // The six tests need a few thousand cycles at most.
  localparam int POLL_LIMIT     = 200;

  logic                           clk;
  logic                           rst_n;
  logic                           key_valid;
  logic                           key_ready;
  logic [`TCAM_KEY_BITS-1:0]      key;
  logic                           res_valid;
  logic                           res_ready;
  logic                           res_hit;
  logic [`TCAM_IDX_BITS-1:0]      res_index;
  logic                           reg_wr;
  logic                           reg_rd;
  logic [`TCAM_REG_ADDR_BITS-1:0] reg_addr;
  logic [31:0]                    reg_wdata;
  logic [31:0]                    reg_rdata;

  logic [`TCAM_KEY_BITS-1:0] model_val [`TCAM_ENTRIES];
  logic [`TCAM_KEY_BITS-1:0] model_msk [`TCAM_ENTRIES];
  bit                        model_vld [`TCAM_ENTRIES];
  logic [31:0]               lcg_state;
  int                        cycles;
  int                        errors;
  int                        checks;
  int                        tests_run;
  int                        tests_failed;
  int                        test_err_start;
  string                     cur_test;

  tcam_subsys_top u_dut (
    .clk, .rst_n, .key_valid, .key_ready, .key, .res_valid, .res_ready, .res_hit,
    .res_index, .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run stopped: no finish within %0d clock cycles.", TIMEOUT_CYCLES);
      $display("test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] cmnd_word(input ia_op_e op, input int idx);
    return {16'h0000, 8'(idx), 4'h0, op};
  endfunction

  // Lowest valid entry whose unmasked bits agree with the key, or -1.
  function automatic int lowest_match(input logic [`TCAM_KEY_BITS-1:0] k);
    for (int e = 0; e < `TCAM_ENTRIES; e++) begin
      if (model_vld[e] && (((k ^ model_val[e]) & model_msk[e]) == '0)) return e;
    end
    return -1;
  endfunction

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERROR %s (%s): expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic open_test(input string name);
    cur_test       = name;
    test_err_start = errors;
    tests_run++;
  endtask

  task automatic report_test();
    if (errors == test_err_start) begin
      $display("%s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("%s: %0d mismatches", cur_test, errors - test_err_start);
    end
  endtask

  // Every bus task starts and ends 2 ns after a rising edge.
  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge clk);
    #2;
    reg_wr = 1'b0;
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(posedge clk);
    #2;
    reg_rd = 1'b0;
    data   = reg_rdata;
  endtask

  task automatic wait_not_busy(output logic [31:0] stat);
    int polls;
    polls = 0;
    reg_read(`TCAM_STAT_ADDR, stat);
    while (stat[3] && polls < POLL_LIMIT) begin
      polls++;
      reg_read(`TCAM_STAT_ADDR, stat);
    end
    if (stat[3]) begin
      errors++;
      $display("%s: controller still busy after %0d status polls", cur_test, POLL_LIMIT);
    end
  endtask

  task automatic write_entry(input int idx, input logic [13:0] val, input logic [13:0] msk);
    logic [31:0] stat;
    reg_write(`TCAM_DATA_ADDR, {2'b11, msk, 2'b11, val});
    reg_write(`TCAM_CMND_ADDR, cmnd_word(WRITE, idx));
    wait_not_busy(stat);
    check("write status", 32'h0000_0f00, stat);
    model_val[idx] = val;
    model_msk[idx] = msk;
    model_vld[idx] = 1'b1;
  endtask

  task automatic read_entry(input int idx, output logic [31:0] word);
    logic [31:0] stat;
    reg_write(`TCAM_CMND_ADDR, cmnd_word(READ, idx));
    wait_not_busy(stat);
    check("read status", 32'h0000_0f00, stat);
    reg_read(`TCAM_DATA_ADDR, word);
  endtask

  task automatic send_key(input logic [`TCAM_KEY_BITS-1:0] k);
    key_valid = 1'b1;
    key       = k;
    while (!key_ready) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk); // Transfer edge.
    #2;
    key_valid = 1'b0;
  endtask

  task automatic take_result(output logic hit, output logic [3:0] idx);
    res_ready = 1'b1;
    while (!res_valid) begin
      @(posedge clk);
      #2;
    end
    hit = res_hit;
    idx = res_index;
    @(posedge clk);
    #2;
    res_ready = 1'b0;
  endtask

  task automatic check_result(input int exp);
    logic       hit;
    logic [3:0] idx;
    take_result(hit, idx);
    check("hit", 32'(exp >= 0), 32'(hit));
    if (exp >= 0) check("index", 32'(exp), 32'(idx));
  endtask

  task automatic draw_key(output logic [`TCAM_KEY_BITS-1:0] k);
    lcg_state = lcg_step(lcg_state);
    k         = lcg_state[29:16];
  endtask

  task automatic test_reset_status();
    logic [31:0] stat;
    open_test("reset_status");
    reg_read(`TCAM_STAT_ADDR, stat);
    check("status after reset", 32'h0000_0000, stat);
    reg_write(`TCAM_CMND_ADDR, cmnd_word(ENABLE, 0));
    reg_read(`TCAM_STAT_ADDR, stat);
    check("status after enable", 32'h0000_0f00, stat);
    report_test();
  endtask

  task automatic test_write_read();
    logic [31:0] word;
    open_test("write_read");
    write_entry(2, 14'h0000, 14'h0003);
    write_entry(5, 14'h2000, 14'h3000);
    write_entry(9, 14'h0001, 14'h0001);
    read_entry(2, word);
    check("entry 2", {2'b11, 14'h0003, 2'b11, 14'h0000}, word);
    read_entry(5, word);
    check("entry 5", {2'b11, 14'h3000, 2'b11, 14'h2000}, word);
    read_entry(9, word);
    check("entry 9", {2'b11, 14'h0001, 2'b11, 14'h0001}, word);
    report_test();
  endtask

  task automatic test_random_lookup();
    logic [`TCAM_KEY_BITS-1:0] k;
    open_test("random_lookup");
    for (int n = 0; n < 40; n++) begin
      draw_key(k);
      send_key(k);
      check_result(lowest_match(k));
    end
    report_test();
  endtask

  task automatic test_backpressure();
    logic [`TCAM_KEY_BITS-1:0] k;
    int                        exp_q[$];
    open_test("backpressure");
    // One result, one key in the array stage and four in the FIFO.
    for (int n = 0; n < 6; n++) begin
      draw_key(k);
      send_key(k);
      exp_q.push_back(lowest_match(k));
    end
    repeat (3) @(posedge clk);
    #2;
    check("key_ready when full", 32'd0, 32'(key_ready));
    while (exp_q.size() > 0) check_result(exp_q.pop_front());
    report_test();
  endtask

  task automatic test_errors();
    logic [31:0] stat;
    open_test("errors");
    reg_write(`TCAM_CMND_ADDR, cmnd_word(READ, 20));
    reg_read(`TCAM_STAT_ADDR, stat);
    check("index out of range", 32'h0000_0f04, stat);
    reg_write(`TCAM_CMND_ADDR, cmnd_word(READ, 1));
    reg_write(`TCAM_CMND_ADDR, cmnd_word(ENABLE, 0));
    reg_read(`TCAM_STAT_ADDR, stat);
    check("error holds", 32'h0000_0f04, stat);
    reg_write(`TCAM_CMND_ADDR, cmnd_word(ACK_ERROR, 0));
    reg_read(`TCAM_STAT_ADDR, stat);
    check("ack after nxm", 32'h0000_0f00, stat);
    reg_write(`TCAM_CMND_ADDR, cmnd_word(READ, 2));
    reg_write(`TCAM_CMND_ADDR, cmnd_word(READ, 5)); // Lands while the first read is busy.
    reg_read(`TCAM_STAT_ADDR, stat);
    check("overrun", 32'h0000_0f03, stat);
    reg_write(`TCAM_CMND_ADDR, cmnd_word(ACK_ERROR, 0));
    reg_read(`TCAM_STAT_ADDR, stat);
    check("ack after ovr", 32'h0000_0f00, stat);
    report_test();
  endtask

  task automatic test_clear();
    logic [31:0] stat;
    logic [31:0] word;
    open_test("clear");
    reg_write(`TCAM_CMND_ADDR, cmnd_word(RESET, 0));
    wait_not_busy(stat);
    check("reset status", 32'h0000_0f00, stat);
    for (int e = 0; e < `TCAM_ENTRIES; e++) model_vld[e] = 1'b0;
    send_key(14'h0000);
    check_result(lowest_match(14'h0000));
    send_key(14'h2001);
    check_result(lowest_match(14'h2001));
    send_key(14'h0005);
    check_result(lowest_match(14'h0005));
    read_entry(2, word);
    check("valid bits after reset", 32'h0000_0000, word & 32'hc000_c000);
    report_test();
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    key_valid    = 1'b0;
    key          = '0;
    res_ready    = 1'b0;
    reg_wr       = 1'b0;
    reg_rd       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    lcg_state    = 32'd62999;
    cycles       = 0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int e = 0; e < `TCAM_ENTRIES; e++) model_vld[e] = 1'b0;

    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;

    test_reset_status();
    test_write_read();
    test_random_lookup();
    test_backpressure();
    test_errors();
    test_clear();

    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== verilog/tcam_array.sv ====
`timescale 1ns/1ps
`include "tcam_config.svh"

module tcam_array
  import tcam_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      hw_ce,
  input  logic [`TCAM_KEY_BITS-1:0] hw_key,
  input  logic                      sw_cs,
  input  logic                      sw_we,
  input  logic [`TCAM_IDX_BITS:0]   sw_row,
  input  tcam_half_s                sw_din,
  input  logic                      sw_clr,
  output logic [`TCAM_ENTRIES-1:0]  match_vec,
  output tcam_half_s                sw_dout
);

  logic [1:0]                val_vld_r [`TCAM_ENTRIES];
  logic [1:0]                msk_vld_r [`TCAM_ENTRIES];
  logic [`TCAM_KEY_BITS-1:0] val_pat_r [`TCAM_ENTRIES];
  logic [`TCAM_KEY_BITS-1:0] msk_pat_r [`TCAM_ENTRIES];
  logic [`TCAM_ENTRIES-1:0]  match_nxt;
  logic [`TCAM_IDX_BITS-1:0] row_idx;
  logic                      row_half;
  logic                      sw_wr;
  logic                      sw_rd;

  assign row_idx  = sw_row[`TCAM_IDX_BITS:1];
  assign row_half = sw_row[0];                // 1 selects the mask row.
  assign sw_wr    = !hw_ce && sw_cs && sw_we; // Searches win the array.
  assign sw_rd    = !hw_ce && sw_cs && !sw_we;

  always_comb begin
    for (int e = 0; e < `TCAM_ENTRIES; e++) begin
      match_nxt[e] = (val_vld_r[e] == 2'b11) && (msk_vld_r[e] == 2'b11) &&
                     (((hw_key ^ val_pat_r[e]) & msk_pat_r[e]) == '0);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int e = 0; e < `TCAM_ENTRIES; e++) begin
        val_vld_r[e] <= 2'b00;
        msk_vld_r[e] <= 2'b00;
      end
    end else if (!hw_ce && sw_clr) begin
      for (int e = 0; e < `TCAM_ENTRIES; e++) begin
        val_vld_r[e] <= 2'b00;
        msk_vld_r[e] <= 2'b00;
      end
    end else if (sw_wr) begin
      if (row_half) msk_vld_r[row_idx] <= sw_din.valid;
      else          val_vld_r[row_idx] <= sw_din.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (sw_wr) begin
      if (row_half) msk_pat_r[row_idx] <= sw_din.pattern;
      else          val_pat_r[row_idx] <= sw_din.pattern;
    end
    if (hw_ce) match_vec <= match_nxt;
    if (sw_rd) begin
      sw_dout.valid   <= row_half ? msk_vld_r[row_idx] : val_vld_r[row_idx];
      sw_dout.pattern <= row_half ? msk_pat_r[row_idx] : val_pat_r[row_idx];
    end
  end

  a_we_needs_cs: assert property (@(posedge clk) disable iff (!rst_n) sw_we |-> sw_cs);

endmodule

// ==== verilog/tcam_indirect_ctrl.sv ====
`timescale 1ns/1ps
`include "tcam_config.svh"

module tcam_indirect_ctrl
  import tcam_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           reg_wr,
  input  logic                           reg_rd,
  input  logic [`TCAM_REG_ADDR_BITS-1:0] reg_addr,
  input  ia_word_u                       reg_wdata,
  input  logic                           hw_ce,
  output logic [31:0]                    reg_rdata,
  output logic                           sw_cs,
  output logic                           sw_we,
  output logic [`TCAM_IDX_BITS:0]        sw_row,
  output tcam_half_s                     sw_din,
  output logic                           sw_clr,
  output logic                           hw_yield,
  input  tcam_half_s                     sw_dout
);

  typedef enum logic [3:0] {
    ST_DISABLED, ST_READY, ST_ERROR, ST_WRITE, ST_WRITE2,
    ST_READ, ST_READ_WAIT, ST_READ_DONE, ST_RESET
  } state_e;

  state_e                      state_r;
  state_e                      state_nxt;
  ia_stat_e                    stat_r;
  ia_stat_e                    err_code;
  ia_cmnd_s                    cmnd;
  ia_word_u                    data_r;
  logic [`TCAM_TIMER_BITS-1:0] timer_r;
  logic [`TCAM_IDX_BITS-1:0]   idx_r;
  logic [1:0]                  clr_cnt_r;
  logic [7:0]                  max_idx;
  logic                        cmnd_issued;
  logic                        busy;
  logic                        err_ovr;
  logic                        err_tmo;
  logic                        err_nxm;

  function automatic logic is_busy(state_e s);
    return s inside {ST_WRITE, ST_WRITE2, ST_READ, ST_READ_WAIT, ST_READ_DONE, ST_RESET};
  endfunction

  assign cmnd        = reg_wdata.cmnd;
  assign cmnd_issued = reg_wr && (reg_addr == `TCAM_CMND_ADDR) &&
                       (cmnd.op inside {READ, WRITE, ENABLE, DISABLE, RESET, ACK_ERROR});
  assign busy        = is_busy(state_r);
  assign max_idx     = (state_r == ST_DISABLED) ? 8'd0 : 8'(`TCAM_ENTRIES - 1);

  assign err_ovr = busy && cmnd_issued;
  assign err_tmo = busy && (&timer_r);
  assign err_nxm = (state_r == ST_READY) && cmnd_issued && (cmnd.op inside {READ, WRITE}) &&
                   (cmnd.index > max_idx);

  assign sw_cs    = busy && (state_r != ST_READ_DONE);
  assign sw_we    = (state_r == ST_WRITE) || (state_r == ST_WRITE2);
  assign sw_clr   = (state_r == ST_RESET);
  assign sw_row   = {idx_r, (state_r == ST_WRITE2) || (state_r == ST_READ_WAIT)};
  assign sw_din   = (state_r == ST_WRITE2) ? data_r.data.mask : data_r.data.value;
  assign hw_yield = timer_r[`TCAM_TIMER_BITS-1]; // Half the timeout asks the engine to pause.

  always_comb begin
    state_nxt = state_r;
    err_code  = NXM;
    if (err_ovr)      err_code = OVR;
    else if (err_tmo) err_code = TMO;

    if (err_ovr || err_tmo || err_nxm) begin
      state_nxt = ST_ERROR;
    end else begin
      case (state_r)
        ST_DISABLED: if (cmnd_issued && cmnd.op == ENABLE) state_nxt = ST_READY;
        ST_READY: begin
          if (cmnd_issued) begin
            case (cmnd.op)
              READ:    state_nxt = ST_READ;
              WRITE:   state_nxt = ST_WRITE;
              RESET:   state_nxt = ST_RESET;
              DISABLE: state_nxt = ST_DISABLED;
              default: state_nxt = ST_READY;
            endcase
          end
        end
        ST_ERROR:     if (cmnd_issued && cmnd.op == ACK_ERROR) state_nxt = ST_READY;
        ST_WRITE:     if (!hw_ce) state_nxt = ST_WRITE2;
        ST_WRITE2:    if (!hw_ce) state_nxt = ST_READY;
        ST_READ:      if (!hw_ce) state_nxt = ST_READ_WAIT;
        ST_READ_WAIT: if (!hw_ce) state_nxt = ST_READ_DONE;
        ST_READ_DONE: state_nxt = ST_READY;
        ST_RESET:     if (!hw_ce && clr_cnt_r == 2'b11) state_nxt = ST_READY;
        default:      state_nxt = ST_DISABLED;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_r   <= ST_DISABLED;
      stat_r    <= RDY;
      timer_r   <= '0;
      clr_cnt_r <= 2'b00;
      reg_rdata <= '0;
    end else begin
      state_r <= state_nxt;
      if (state_nxt == ST_ERROR) begin
        if (state_r != ST_ERROR) stat_r <= err_code; // The first error code sticks.
      end else begin
        stat_r <= is_busy(state_nxt) ? BSY : RDY;
      end

      // Only cycles lost to searches count toward yield and timeout.
      if (!is_busy(state_nxt))  timer_r <= '0;
      else if (sw_cs && hw_ce)  timer_r <= timer_r + 1'b1;

      if (sw_clr && !hw_ce)          clr_cnt_r <= clr_cnt_r + 1'b1;
      else if (state_r != ST_RESET)  clr_cnt_r <= 2'b00;

      if (reg_rd) begin
        case (reg_addr)
          `TCAM_STAT_ADDR: reg_rdata <= {16'h0000, max_idx, 4'h0, busy, stat_r};
          `TCAM_DATA_ADDR: reg_rdata <= data_r;
          default:         reg_rdata <= '0;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_r == ST_READY && cmnd_issued) idx_r <= cmnd.index[`TCAM_IDX_BITS-1:0];
    if (reg_wr && reg_addr == `TCAM_DATA_ADDR) data_r <= reg_wdata;
    if (state_r == ST_READ_WAIT) data_r.data.value <= sw_dout; // Value row from the first read.
    if (state_r == ST_READ_DONE) data_r.data.mask  <= sw_dout;
  end

  a_we_clr_excl: assert property (@(posedge clk) disable iff (!rst_n) !(sw_we && sw_clr));
  a_cs_busy: assert property (@(posedge clk) disable iff (!rst_n) sw_cs |-> stat_r == BSY);

endmodule

// ==== verilog/tcam_key_fifo.sv ====
`timescale 1ns/1ps
`include "tcam_config.svh"

module tcam_key_fifo (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  input  logic [`TCAM_KEY_BITS-1:0] in_key,
  output logic                      in_ready,
  output logic                      out_valid,
  output logic [`TCAM_KEY_BITS-1:0] out_key,
  input  logic                      out_ready
);

  localparam int DEPTH = `TCAM_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  logic [`TCAM_KEY_BITS-1:0] mem [DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [PTR_W:0]            count;
  logic                      push;
  logic                      pop;

  assign in_ready  = (count != (PTR_W + 1)'(DEPTH));
  assign out_valid = (count != '0);
  assign out_key   = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_key;
  end

  // A full buffer must not advance its write side on the next edge.
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    count == (PTR_W + 1)'(DEPTH) |=> $stable(wr_ptr));

endmodule

// ==== verilog/tcam_lookup_engine.sv ====
`timescale 1ns/1ps
`include "tcam_config.svh"

module tcam_lookup_engine (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      fifo_valid,
  input  logic [`TCAM_KEY_BITS-1:0] fifo_key,
  input  logic                      hw_yield,
  input  logic [`TCAM_ENTRIES-1:0]  match_vec,
  input  logic                      res_ready,
  output logic                      fifo_ready,
  output logic                      hw_ce,
  output logic [`TCAM_KEY_BITS-1:0] hw_key,
  output logic                      res_valid,
  output logic                      res_hit,
  output logic [`TCAM_IDX_BITS-1:0] res_index
);

  localparam int IDX_W = `TCAM_IDX_BITS;

  logic             stage_busy_r; // A key occupies the array stage.
  logic             advance;
  logic             pop;
  logic             hit_nxt;
  logic [IDX_W-1:0] idx_nxt;

  // The match is ready once the search cycle is over and the result slot frees up.
  assign advance    = stage_busy_r && !hw_ce && (!res_valid || res_ready);
  assign fifo_ready = !hw_yield && (!stage_busy_r || advance);
  assign pop        = fifo_valid && fifo_ready;

  // Lowest index wins.
  always_comb begin
    hit_nxt = 1'b0;
    idx_nxt = '0;
    for (int e = `TCAM_ENTRIES - 1; e >= 0; e--) begin
      if (match_vec[e]) begin
        hit_nxt = 1'b1;
        idx_nxt = IDX_W'(e);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hw_ce        <= 1'b0;
      stage_busy_r <= 1'b0;
      res_valid    <= 1'b0;
    end else begin
      hw_ce        <= pop;
      stage_busy_r <= pop || (stage_busy_r && !advance);
      res_valid    <= advance || (res_valid && !res_ready);
    end
  end

  always_ff @(posedge clk) begin
    if (pop) hw_key <= fifo_key;
    if (advance) begin
      res_hit   <= hit_nxt;
      res_index <= idx_nxt;
    end
  end

  // A search never starts in the cycle after yield was seen.
  a_yield_blocks: assert property (@(posedge clk) disable iff (!rst_n)
    $past(hw_yield) |-> !hw_ce);

endmodule

// ==== verilog/tcam_pkg.sv ====
`include "tcam_config.svh"

package tcam_pkg;

  typedef enum logic [3:0] {
    NOP       = 4'h0,
    READ      = 4'h1,
    WRITE     = 4'h2,
    ENABLE    = 4'h3,
    DISABLE   = 4'h4,
    RESET     = 4'h5,
    ACK_ERROR = 4'hf
  } ia_op_e;

  typedef enum logic [2:0] {
    RDY = 3'h0,
    BSY = 3'h1,
    TMO = 3'h2,
    OVR = 3'h3,
    NXM = 3'h4
  } ia_stat_e;

  // One row of an entry. Both rows need valid 2'b11 for the entry to take part.
  typedef struct packed {
    logic [1:0]                valid;
    logic [`TCAM_KEY_BITS-1:0] pattern;
  } tcam_half_s;

  typedef struct packed {
    logic [15:0] rsvd_hi;
    logic [7:0]  index;
    logic [3:0]  rsvd_lo;
    ia_op_e      op;
  } ia_cmnd_s;

  typedef struct packed {
    tcam_half_s mask;
    tcam_half_s value;
  } ia_data_s;

  // A register write is a command or entry data, depending on its address.
  typedef union packed {
    ia_cmnd_s cmnd;
    ia_data_s data;
  } ia_word_u;

endpackage

// ==== verilog/tcam_subsys_top.sv ====
`timescale 1ns/1ps
`include "tcam_config.svh"

module tcam_subsys_top
  import tcam_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           key_valid,
  output logic                           key_ready,
  input  logic [`TCAM_KEY_BITS-1:0]      key,
  output logic                           res_valid,
  input  logic                           res_ready,
  output logic                           res_hit,
  output logic [`TCAM_IDX_BITS-1:0]      res_index,
  input  logic                           reg_wr,
  input  logic                           reg_rd,
  input  logic [`TCAM_REG_ADDR_BITS-1:0] reg_addr,
  input  logic [31:0]                    reg_wdata,
  output logic [31:0]                    reg_rdata
);

  logic                      fifo_valid;
  logic                      fifo_ready;
  logic [`TCAM_KEY_BITS-1:0] fifo_key;
  logic                      hw_ce;
  logic [`TCAM_KEY_BITS-1:0] hw_key;
  logic                      hw_yield;
  logic [`TCAM_ENTRIES-1:0]  match_vec;
  logic                      sw_cs;
  logic                      sw_we;
  logic                      sw_clr;
  logic [`TCAM_IDX_BITS:0]   sw_row;
  tcam_half_s                sw_din;
  tcam_half_s                sw_dout;

  tcam_key_fifo u_fifo (
    .clk, .rst_n,
    .in_valid(key_valid), .in_key(key), .in_ready(key_ready),
    .out_valid(fifo_valid), .out_key(fifo_key), .out_ready(fifo_ready)
  );

  tcam_lookup_engine u_engine (
    .clk, .rst_n,
    .fifo_valid, .fifo_key, .hw_yield, .match_vec, .res_ready,
    .fifo_ready, .hw_ce, .hw_key, .res_valid, .res_hit, .res_index
  );

  tcam_indirect_ctrl u_ctrl (
    .clk, .rst_n,
    .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .hw_ce, .reg_rdata,
    .sw_cs, .sw_we, .sw_row, .sw_din, .sw_clr, .hw_yield, .sw_dout
  );

  tcam_array u_array (
    .clk, .rst_n,
    .hw_ce, .hw_key, .sw_cs, .sw_we, .sw_row, .sw_din, .sw_clr,
    .match_vec, .sw_dout
  );

endmodule
